//--- vic_timing_pkg.sv
package vic_timing_pkg;

    // chip flavour, latched while reset is held
    typedef enum logic {
        chip_pal  = 1'b0,
        chip_ntsc = 1'b1
    } chip_t;

    typedef logic [9:0] raster_x_t;     // pixel within a line
    typedef logic [8:0] raster_line_t;  // line within a frame
    typedef logic [4:0] phase_t;        // dot4x phase within one phi cycle

    localparam int dots_per_phi = 32;   // 8 pixels of 4 clocks each

    // --------------------
    // pal geometry
    localparam raster_x_t    pal_line_pixels    = 10'd504;
    localparam raster_line_t pal_frame_lines    = 9'd312;
    localparam raster_x_t    pal_visible_pixels = 10'd404;
    localparam raster_line_t pal_vis_line_first = 9'd16;
    localparam raster_line_t pal_vis_line_last  = 9'd283;
    localparam raster_x_t    pal_hsync_start    = 10'd416;
    localparam raster_x_t    pal_hsync_len      = 10'd36;   // vga pulse
    localparam raster_x_t    pal_csync_len      = 10'd32;   // composite pulse
    localparam raster_line_t pal_vsync_start    = 9'd300;

    // --------------------
    // ntsc geometry
    localparam raster_x_t    ntsc_line_pixels    = 10'd520;
    localparam raster_line_t ntsc_frame_lines    = 9'd263;
    localparam raster_x_t    ntsc_visible_pixels = 10'd418;
    localparam raster_line_t ntsc_vis_line_first = 9'd16;
    localparam raster_line_t ntsc_vis_line_last  = 9'd234;
    localparam raster_x_t    ntsc_hsync_start    = 10'd432;
    localparam raster_x_t    ntsc_hsync_len      = 10'd38;
    localparam raster_x_t    ntsc_csync_len      = 10'd32;
    localparam raster_line_t ntsc_vsync_start    = 9'd250;

    localparam raster_line_t vsync_lines = 9'd3;   // same for both chips

    function automatic raster_x_t line_pixels(chip_t c);
        return (c == chip_ntsc) ? ntsc_line_pixels : pal_line_pixels;
    endfunction

    function automatic raster_line_t frame_lines(chip_t c);
        return (c == chip_ntsc) ? ntsc_frame_lines : pal_frame_lines;
    endfunction

    // first pixel of the line sync pulse, shared by vga and composite
    function automatic raster_x_t hsync_start(chip_t c);
        return (c == chip_ntsc) ? ntsc_hsync_start : pal_hsync_start;
    endfunction

    // visible window, the same for both output paths
    function automatic logic in_visible(chip_t c, raster_x_t x, raster_line_t y);
        raster_x_t    x_lim;
        raster_line_t y_first;
        raster_line_t y_last;
        x_lim   = (c == chip_ntsc) ? ntsc_visible_pixels : pal_visible_pixels;
        y_first = (c == chip_ntsc) ? ntsc_vis_line_first : pal_vis_line_first;
        y_last  = (c == chip_ntsc) ? ntsc_vis_line_last : pal_vis_line_last;
        return (x < x_lim) && (y >= y_first) && (y <= y_last);
    endfunction

    function automatic logic in_vsync(chip_t c, raster_line_t y);
        raster_line_t y_start;
        y_start = (c == chip_ntsc) ? ntsc_vsync_start : pal_vsync_start;
        return (y >= y_start) && (y < y_start + vsync_lines);
    endfunction

endpackage

//--- vic_color_pkg.sv
package vic_color_pkg;

    typedef logic [3:0] color_idx_t;   // vic palette index
    typedef logic [2:0] chan_t;        // one dac channel, 3 bits

    typedef chan_t palette_t [16];

    localparam color_idx_t color_black = 4'd0;   // blanking level

    // --------------------
    // vic palette, 8 bit levels cut down to the top 3 bits
    // order: black, white, red, cyan, purple, green, blue, yellow,
    //        orange, brown, light red, dark grey, grey,
    //        light green, light blue, light grey

    localparam palette_t palette_red = '{
        3'd0, 3'd7, 3'd3, 3'd3,
        3'd3, 3'd2, 3'd1, 3'd5,
        3'd3, 3'd2, 3'd4, 3'd2,
        3'd3, 3'd4, 3'd3, 3'd4
    };

    localparam palette_t palette_green = '{
        3'd0, 3'd7, 3'd1, 3'd5,
        3'd1, 3'd4, 3'd1, 3'd6,
        3'd2, 3'd1, 3'd3, 3'd2,
        3'd3, 3'd6, 3'd2, 3'd4
    };

    localparam palette_t palette_blue = '{
        3'd0, 3'd7, 3'd1, 3'd5,
        3'd4, 3'd2, 3'd3, 3'd3,
        3'd1, 3'd0, 3'd2, 3'd2,
        3'd3, 3'd4, 3'd5, 3'd4
    };

endpackage

//--- raster_counter.sv
`timescale 1ns/1ps

module raster_counter (
    input  logic                         clk_dot4x,
    input  logic                         rst_n,
    input  vic_timing_pkg::chip_t        chip,         // raw chip strap
    output vic_timing_pkg::chip_t        chip_sel,     // strap frozen at reset release
    output vic_timing_pkg::raster_x_t    raster_x,
    output vic_timing_pkg::raster_line_t raster_line,
    output logic                         pixel_tick,   // last dot4x of a pixel
    output logic                         clk_phi,
    output logic                         cpu_reset
);

    import vic_timing_pkg::*;

    phase_t       phase;      // position inside one phi cycle
    raster_x_t    x_last;     // last pixel of the current line
    raster_line_t line_last;  // last line of the frame

    // --------------------
    // chip strap

    // sampled on every clock while reset is low, held afterwards
    always_ff @(posedge clk_dot4x) begin
        if (!rst_n) begin
            chip_sel <= chip;
        end
    end

    // --------------------
    // dot phase and phi

    always_ff @(posedge clk_dot4x) begin
        if (!rst_n) begin
            phase <= '0;
        end else if (phase == phase_t'(dots_per_phi - 1)) begin
            phase <= '0;                   // end of phi cycle
        end else begin
            phase <= phase + phase_t'(1);
        end
    end

    assign pixel_tick = (phase[1:0] == 2'b11);  // every 4th clock
    assign clk_phi    = phase[4];               // low 0..15, high 16..31

    // cpu held in reset one clock past rst_n release
    always_ff @(posedge clk_dot4x) begin
        if (!rst_n) begin
            cpu_reset <= 1'b1;
        end else begin
            cpu_reset <= 1'b0;
        end
    end

    // --------------------
    // raster position

    assign x_last    = line_pixels(chip_sel) - raster_x_t'(1);
    assign line_last = frame_lines(chip_sel) - raster_line_t'(1);

    always_ff @(posedge clk_dot4x) begin
        if (!rst_n) begin
            raster_x    <= '0;
            raster_line <= '0;
        end else if (pixel_tick) begin
            if (raster_x == x_last) begin
                raster_x <= '0;            // line wrap
                if (raster_line == line_last) begin
                    raster_line <= '0;     // frame wrap
                end else begin
                    raster_line <= raster_line + raster_line_t'(1);
                end
            end else begin
                raster_x <= raster_x + raster_x_t'(1);
            end
        end
    end

endmodule

//--- vga_sync.sv
`timescale 1ns/1ps

module vga_sync (
    input  logic                         clk_dot4x,
    input  logic                         rst_n,
    input  vic_timing_pkg::chip_t        chip_sel,
    input  vic_timing_pkg::raster_x_t    raster_x,
    input  vic_timing_pkg::raster_line_t raster_line,
    input  vic_color_pkg::color_idx_t    pixel_color,   // from the vic core
    output logic                         hsync_raw,     // active low
    output logic                         vsync_raw,     // active low
    output logic                         active_raw,
    output vic_color_pkg::color_idx_t    vga_pixel
);

    import vic_timing_pkg::*;
    import vic_color_pkg::*;

    raster_x_t hs_start;
    raster_x_t hs_len;
    raster_x_t hs_end;      // first pixel after the pulse
    logic      hs_win;
    logic      vs_win;
    logic      vis_win;

    // --------------------
    // window decode

    assign hs_start = hsync_start(chip_sel);
    assign hs_len   = (chip_sel == chip_ntsc) ? ntsc_hsync_len : pal_hsync_len;
    assign hs_end   = hs_start + hs_len;

    assign hs_win  = (raster_x >= hs_start) && (raster_x < hs_end);
    assign vs_win  = in_vsync(chip_sel, raster_line);
    assign vis_win = in_visible(chip_sel, raster_x, raster_line);

    // --------------------
    // sync register

    // one clock behind the position it decodes
    always_ff @(posedge clk_dot4x) begin
        if (!rst_n) begin
            hsync_raw  <= 1'b1;    // inactive
            vsync_raw  <= 1'b1;
            active_raw <= 1'b0;
        end else begin
            hsync_raw  <= ~hs_win;
            vsync_raw  <= ~vs_win;
            active_raw <= vis_win;
        end
    end

    // pixel taken on the same edge, black outside the window
    always_ff @(posedge clk_dot4x) begin
        if (vis_win) begin
            vga_pixel <= pixel_color;
        end else begin
            vga_pixel <= color_black;
        end
    end

endmodule

//--- comp_sync.sv
`timescale 1ns/1ps

module comp_sync (
    input  logic                         clk_dot4x,
    input  logic                         rst_n,
    input  vic_timing_pkg::chip_t        chip_sel,
    input  vic_timing_pkg::raster_x_t    raster_x,
    input  vic_timing_pkg::raster_line_t raster_line,
    input  vic_color_pkg::color_idx_t    pixel_color,
    output logic                         csync_raw,    // active low
    output vic_color_pkg::color_idx_t    comp_pixel
);

    import vic_timing_pkg::*;
    import vic_color_pkg::*;

    raster_x_t cs_start;
    raster_x_t cs_len;
    raster_x_t cs_end;
    logic      hs_win;      // composite line pulse
    logic      vs_line;     // inside the vsync lines
    logic      vis_win;

    // --------------------
    // line pulse

    // starts where the vga pulse starts, but is shorter
    assign cs_start = hsync_start(chip_sel);
    assign cs_len   = (chip_sel == chip_ntsc) ? ntsc_csync_len : pal_csync_len;
    assign cs_end   = cs_start + cs_len;

    assign hs_win = (raster_x >= cs_start) && (raster_x < cs_end);

    // --------------------
    // field pulse and blanking

    assign vs_line = in_vsync(chip_sel, raster_line);
    assign vis_win = in_visible(chip_sel, raster_x, raster_line);   // same as vga

    // on vsync lines the pulse flips: high in the window, low elsewhere
    always_ff @(posedge clk_dot4x) begin
        if (!rst_n) begin
            csync_raw <= 1'b1;               // idle level
        end else if (vs_line) begin
            csync_raw <= hs_win;
        end else begin
            csync_raw <= ~hs_win;
        end
    end

    // blanked index for the composite path
    always_ff @(posedge clk_dot4x) begin
        comp_pixel <= vis_win ? pixel_color : color_black;
    end

endmodule

//--- color_palette.sv
`timescale 1ns/1ps

module color_palette (
    input  logic                      clk_dot4x,
    input  logic                      rst_n,
    input  logic                      is_composite,  // 1 = composite path
    input  vic_color_pkg::color_idx_t vga_pixel,
    input  vic_color_pkg::color_idx_t comp_pixel,
    input  logic                      hsync_raw,
    input  logic                      vsync_raw,
    input  logic                      active_raw,
    input  logic                      csync_raw,
    output vic_color_pkg::chan_t      red,
    output vic_color_pkg::chan_t      green,
    output vic_color_pkg::chan_t      blue,
    output logic                      hsync,
    output logic                      vsync,
    output logic                      active,
    output logic                      csync
);

    import vic_color_pkg::*;

    color_idx_t out_pixel;   // index after path select

    assign out_pixel = is_composite ? comp_pixel : vga_pixel;

    // --------------------
    // output stage

    // rgb lookup and the sync delay share one edge so they stay aligned
    always_ff @(posedge clk_dot4x) begin
        if (!rst_n) begin
            red    <= '0;
            green  <= '0;
            blue   <= '0;
            hsync  <= 1'b1;      // syncs idle high
            vsync  <= 1'b1;
            csync  <= 1'b1;
            active <= 1'b0;
        end else begin
            red    <= palette_red[out_pixel];
            green  <= palette_green[out_pixel];
            blue   <= palette_blue[out_pixel];
            hsync  <= hsync_raw;
            vsync  <= vsync_raw;
            csync  <= csync_raw;
            active <= active_raw;
        end
    end

endmodule

//--- vic_video_out.sv
`timescale 1ns/1ps

module vic_video_out (
    input  logic                         clk_dot4x,
    input  logic                         rst_n,
    input  vic_timing_pkg::chip_t        chip,          // strap, read during reset
    input  logic                         is_composite,  // 1 = composite, 0 = vga/hdmi
    input  vic_color_pkg::color_idx_t    pixel_color,   // index from the vic core
    output vic_timing_pkg::raster_x_t    raster_x,
    output vic_timing_pkg::raster_line_t raster_line,
    output logic                         clk_phi,
    output logic                         cpu_reset,
    output logic                         hsync,
    output logic                         vsync,
    output logic                         active,
    output logic                         csync,
    output vic_color_pkg::chan_t         red,
    output vic_color_pkg::chan_t         green,
    output vic_color_pkg::chan_t         blue
);

    import vic_timing_pkg::*;
    import vic_color_pkg::*;

    chip_t      chip_sel;
    logic       hsync_raw;
    logic       vsync_raw;
    logic       active_raw;
    logic       csync_raw;
    color_idx_t vga_pixel;
    color_idx_t comp_pixel;

    // --------------------
    // raster timing and phi
    raster_counter i_raster_counter (
        .clk_dot4x   (clk_dot4x),
        .rst_n       (rst_n),
        .chip        (chip),
        .chip_sel    (chip_sel),
        .raster_x    (raster_x),
        .raster_line (raster_line),
        .pixel_tick  (),            // only the counter itself steps on it
        .clk_phi     (clk_phi),
        .cpu_reset   (cpu_reset)
    );

    // vga/hdmi sync
    vga_sync i_vga_sync (
        .clk_dot4x   (clk_dot4x),
        .rst_n       (rst_n),
        .chip_sel    (chip_sel),
        .raster_x    (raster_x),
        .raster_line (raster_line),
        .pixel_color (pixel_color),
        .hsync_raw   (hsync_raw),
        .vsync_raw   (vsync_raw),
        .active_raw  (active_raw),
        .vga_pixel   (vga_pixel)
    );

    // composite sync
    comp_sync i_comp_sync (
        .clk_dot4x   (clk_dot4x),
        .rst_n       (rst_n),
        .chip_sel    (chip_sel),
        .raster_x    (raster_x),
        .raster_line (raster_line),
        .pixel_color (pixel_color),
        .csync_raw   (csync_raw),
        .comp_pixel  (comp_pixel)
    );

    // --------------------
    // palette and output register
    color_palette i_color_palette (
        .clk_dot4x    (clk_dot4x),
        .rst_n        (rst_n),
        .is_composite (is_composite),
        .vga_pixel    (vga_pixel),
        .comp_pixel   (comp_pixel),
        .hsync_raw    (hsync_raw),
        .vsync_raw    (vsync_raw),
        .active_raw   (active_raw),
        .csync_raw    (csync_raw),
        .red          (red),
        .green        (green),
        .blue         (blue),
        .hsync        (hsync),
        .vsync        (vsync),
        .active       (active),
        .csync        (csync)
    );

endmodule

//--- vic_video_out_properties.sv
`timescale 1ns/1ps

module vic_video_out_properties (
    input  logic                         clk_dot4x,
    input  logic                         rst_n,
    input  vic_timing_pkg::chip_t        chip_sel,
    input  vic_timing_pkg::raster_x_t    raster_x,
    input  logic                         clk_phi,
    input  logic                         hsync,
    input  logic                         vsync,
    input  logic                         active,
    input  vic_color_pkg::chan_t         red,
    input  vic_color_pkg::chan_t         green,
    input  vic_color_pkg::chan_t         blue
);

    import vic_timing_pkg::*;

    logic      phi_q, hs_q, vs_q;
    int        phi_run;                 // clocks the current phi level has lasted
    int        hs_run;                  // clocks of hsync low so far
    raster_x_t x_d1, x_d2, x_d3;        // raster_x history

    always_ff @(posedge clk_dot4x) begin
        phi_q <= clk_phi;
        hs_q  <= hsync;
        vs_q  <= vsync;
        x_d1  <= raster_x;
        x_d2  <= x_d1;
        x_d3  <= x_d2;
        if (!rst_n) begin
            phi_run <= 0;
            hs_run  <= 0;
        end else begin
            phi_run <= (clk_phi != phi_q) ? 1 : phi_run + 1;
            hs_run  <= hsync ? 0 : hs_run + 1;
        end
    end

    // --------------------
    phi_half: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
        (clk_phi != phi_q) |-> (phi_run == 16)) else $error("clk_phi half period not 16");

    blank_black: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
        !active |-> ({red, green, blue} == '0)) else $error("rgb not black while blanked");

    hsync_width: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
        (hsync && !hs_q) |->
        (hs_run == 4 * int'(chip_sel == chip_ntsc ? ntsc_hsync_len : pal_hsync_len)))
        else $error("hsync pulse width wrong");

    // vsync edges sit at the output stage of a line start
    vsync_edge: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
        (vsync != vs_q) |-> (x_d2 == '0 && x_d3 != '0)) else $error("vsync moved mid line");

endmodule

bind vic_video_out vic_video_out_properties i_vic_video_out_properties (.*);

//--- tb_vic_video_out.sv
`timescale 1ns/1ps

module tb_vic_video_out;

    import vic_timing_pkg::*;
    import vic_color_pkg::*;

    // two pal frames and one ntsc frame of 40 ns clocks plus 10%
    localparam longint watchdog_ns =
        (2 * 504 * 312 + 520 * 263) * 4 * 40 * 11 / 10;

    logic         clk_dot4x = 1'b0;
    logic         rst_n;
    logic         rst_req;                 // applied 2 ns after the next edge
    chip_t        chip;
    logic         is_composite;
    color_idx_t   pixel_color;
    raster_x_t    raster_x;
    raster_line_t raster_line;
    logic         clk_phi, cpu_reset, hsync, vsync, active, csync;
    chan_t        red, green, blue;

    int           errs = 0;
    int           checks = 0;
    logic [31:0]  rng;
    chip_t        mchip;                   // chip the model expects
    int           mk;                      // clocks since reset release
    raster_x_t    mx;
    raster_line_t my;
    raster_x_t    hx [2];                  // [1] is two cycles back
    raster_line_t hy [2];
    color_idx_t   hc [2];
    int           hv;

    vic_video_out i_vic_video_out (.*);

    always #20 clk_dot4x = ~clk_dot4x;

    // --------------------
    // compare tasks

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    task automatic report(input string name, input int got, input int exp);
        errs++;
        $display("ERR %0t %s got %0d exp %0d", $time, name, got, exp);
    endtask

    task automatic chan_cmp(input string name, input chan_t got, input chan_t exp);
        checks++;
        if (got !== exp) report(name, int'(got), int'(exp));
    endtask

    task automatic level_cmp(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) report(name, int'(got), int'(exp));
    endtask

    task automatic x_cmp(input string name, input raster_x_t got, input raster_x_t exp);
        checks++;
        if (got !== exp) report(name, int'(got), int'(exp));
    endtask

    task automatic line_cmp(input string name, input raster_line_t got,
                            input raster_line_t exp);
        checks++;
        if (got !== exp) report(name, int'(got), int'(exp));
    endtask

    task automatic count_cmp(input string name, input int got, input int exp);
        checks++;
        if (got != exp) report(name, got, exp);
    endtask

    // rgb of an index or black when blanked
    task automatic rgb_cmp(input color_idx_t idx, input logic shown);
        chan_cmp("red", red, shown ? palette_red[idx] : chan_t'(0));
        chan_cmp("green", green, shown ? palette_green[idx] : chan_t'(0));
        chan_cmp("blue", blue, shown ? palette_blue[idx] : chan_t'(0));
    endtask

    // expected syncs for a position two cycles back
    task automatic video_check(input raster_x_t x, input raster_line_t y, input color_idx_t c);
        logic      ntsc;
        raster_x_t hs;
        logic      vga_win, comp_win, vs, vis;
        ntsc     = (mchip == chip_ntsc);
        hs       = ntsc ? 10'd432 : 10'd416;
        vga_win  = (x >= hs) && (x < hs + (ntsc ? 10'd38 : 10'd36));
        comp_win = (x >= hs) && (x < hs + 10'd32);
        vs       = ntsc ? (y >= 9'd250 && y < 9'd253) : (y >= 9'd300 && y < 9'd303);
        vis      = (x < (ntsc ? 10'd418 : 10'd404)) && (y >= 9'd16)
                   && (y <= (ntsc ? 9'd234 : 9'd283));
        level_cmp("hsync", hsync, !vga_win);
        level_cmp("vsync", vsync, !vs);
        level_cmp("active", active, vis);
        level_cmp("csync", csync, vs ? comp_win : !comp_win);  // flipped on vsync lines
        rgb_cmp(c, vis);
    endtask

    // --------------------
    // one clock of model update, checks and drive

    task automatic step();
        @(posedge clk_dot4x);
        #2;
        if (rst_n) begin
            mk++;
            if (mk % 4 == 0) begin                       // pixel boundary
                if (mx == (mchip == chip_ntsc ? 10'd519 : 10'd503)) begin
                    mx = '0;
                    my = (my == (mchip == chip_ntsc ? 9'd262 : 9'd311)) ? 9'd0 : my + 9'd1;
                end else begin
                    mx = mx + 10'd1;
                end
            end
            x_cmp("raster_x", raster_x, mx);
            line_cmp("raster_line", raster_line, my);
            level_cmp("clk_phi", clk_phi, (mk % 32) >= 16);
            level_cmp("cpu_reset", cpu_reset, 1'b0);
            if (hv >= 2) video_check(hx[1], hy[1], hc[1]);
        end else begin
            level_cmp("hsync", hsync, 1'b1);                // reset levels
            level_cmp("vsync", vsync, 1'b1);
            level_cmp("csync", csync, 1'b1);
            level_cmp("active", active, 1'b0);
            level_cmp("cpu_reset", cpu_reset, 1'b1);
            level_cmp("clk_phi", clk_phi, 1'b0);
            x_cmp("raster_x", raster_x, '0);
            line_cmp("raster_line", raster_line, '0);
            rgb_cmp(color_black, 1'b0);
            mchip = chip;
            mk = 0;
            mx = '0;
            my = '0;
            hv = 0;
        end
        rst_n = rst_req;
        rng = xorshift32(rng);
        pixel_color = rng[3:0] ^ raster_x[3:0];            // core color follows position
        hx[1] = hx[0];
        hy[1] = hy[0];
        hc[1] = hc[0];
        hx[0] = raster_x;
        hy[0] = raster_line;
        hc[0] = pixel_color;
        hv++;
    endtask

    // 8 clock edges with rst_n low
    task automatic apply_reset(input chip_t c);
        chip = c;
        rst_n = 1'b0;
        rst_req = 1'b0;
        repeat (7) step();
        rst_req = 1'b1;
        step();
    endtask

    // runs until the line counter wraps and checks both wrap points
    task automatic run_frame(input raster_x_t x_end, input raster_line_t y_end,
                             output int lines, output int lit, output int flipped);
        raster_x_t    px;
        raster_line_t py;
        int           n;
        logic         done;
        lines = 0;
        lit = 0;
        flipped = 0;
        n = 0;
        done = 1'b0;
        while (!done && n < 660000) begin
            px = raster_x;
            py = raster_line;
            step();
            n++;
            if (active) lit++;
            if (!vsync && csync) flipped++;
            if (raster_x != px && raster_x == '0) begin
                x_cmp("raster_x at wrap", px, x_end);
                lines++;
            end
            if (raster_line != py && raster_line == '0) begin
                line_cmp("raster_line at wrap", py, y_end);
                done = 1'b1;
            end
        end
        if (!done) begin
            $display("no frame wrap seen within %0d clocks", n);
            errs++;
        end
    endtask

    // --------------------
    // directed tests

    task automatic reset_phi_test();
        apply_reset(chip_pal);
        repeat (64) step();                                  // 2 phi cycles or 16 pixels
        x_cmp("raster_x after 64 clocks", raster_x, 10'd16);
    endtask

    task automatic pal_vga_test();
        int lines, lit, flipped;
        run_frame(10'd503, 9'd311, lines, lit, flipped);
        count_cmp("pal lines", lines, 312);
        count_cmp("pal active clocks", lit, 404 * 268 * 4);
    endtask

    task automatic composite_test();
        int lines, lit, flipped;
        is_composite = 1'b1;
        run_frame(10'd503, 9'd311, lines, lit, flipped);
        count_cmp("csync high in vsync", flipped, 3 * 32 * 4);
        is_composite = 1'b0;
    endtask

    task automatic ntsc_test();
        int lines, lit, flipped;
        apply_reset(chip_ntsc);
        chip = chip_pal;                                     // must be ignored now
        run_frame(10'd519, 9'd262, lines, lit, flipped);
        count_cmp("ntsc lines", lines, 263);
        count_cmp("ntsc active clocks", lit, 418 * 219 * 4);
    endtask

    initial begin
        rst_n = 1'b0;
        rst_req = 1'b0;
        chip = chip_pal;
        is_composite = 1'b0;
        pixel_color = '0;
        rng = 32'd14;
        reset_phi_test();
        pal_vga_test();
        composite_test();
        ntsc_test();
        $display("checks %0d errors %0d", checks, errs);
        if (errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(watchdog_ns);
        $display("timeout, tests did not finish in %0d ns", watchdog_ns);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- vlog.f
vic_timing_pkg.sv
vic_color_pkg.sv
raster_counter.sv
vga_sync.sv
comp_sync.sv
color_palette.sv
vic_video_out.sv
vic_video_out_properties.sv
tb_vic_video_out.sv

//--- Makefile
# Verilator build and run for the video output testbench

VERILATOR ?= verilator
TOP       ?= tb_vic_video_out
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' vlog.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) vlog.f
	$(VERILATOR) $(VFLAGS) -f vlog.f --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
